// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := txTimeTb
FILELIST  := all.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass is decided by the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(OBJDIR)

// File: all.f
verilog/txTimePkg.sv
verilog/txTimeIfs.sv
verilog/txTimeRegs.sv
verilog/txTimeCtrl.sv
verilog/symbolDivider.sv
verilog/txTimeTop.sv
verification/txTimeTop_assertions.sv
verification/txTimeTb.sv

// File: verification/txTimeTb.sv
// TX time calculator testbench
`timescale 1ns/1ps

module txTimeTb import txTimePkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int RANDOM_CASES    = 20;
  localparam int STALL_CASES     = 5;
  localparam int TEST_COUNT      = 6 + RANDOM_CASES + STALL_CASES; // Directed cases and runs
  localparam int WATCHDOG_CYCLES = TEST_COUNT * 200;

  logic                        macCoreClk;
  logic                        macCoreClkHardRst_n;
  logic [AXI_ADDR_WIDTH-1:0]   awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [AXI_DATA_WIDTH-1:0]   wdata;
  logic [AXI_DATA_WIDTH/8-1:0] wstrb;
  logic                        wvalid;
  logic                        wready;
  axiResp_t                    bresp;
  logic                        bvalid;
  logic                        bready;
  logic [AXI_ADDR_WIDTH-1:0]   araddr;
  logic                        arvalid;
  logic                        arready;
  logic [AXI_DATA_WIDTH-1:0]   rdata;
  axiResp_t                    rresp;
  logic                        rvalid;
  logic                        rready;
  logic                        txTimeDone_p;
  string                       testName;
  int                          stallMax      = 0;   // Hold-off bound for bready and rready
  int                          doneCount     = 0;   // Interrupt pulses seen
  int                          expectedDones = 0;

  txTimeTop txTimeTop_inst
  (
    .macCoreClk (macCoreClk), .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata  (wdata),  .wstrb   (wstrb),   .wvalid  (wvalid), .wready (wready),
    .bresp  (bresp),  .bvalid  (bvalid),  .bready  (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata  (rdata),  .rresp   (rresp),   .rvalid  (rvalid), .rready (rready),
    .txTimeDone_p (txTimeDone_p)
  );

  bind txTimeTop txTimeTop_assertions txTimeTop_assertions_inst
  (
    .macCoreClk (macCoreClk), .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .bvalid (bvalid), .bready (bready), .bresp (bresp),
    .rvalid (rvalid), .rready (rready), .rdata (rdata),
    .divDone_p (divBus.divDone_p), .busy (cfgBus.busy), .txTimeDone_p (txTimeDone_p)
  );

  initial
  begin
    macCoreClk = 1'b0;
    forever #(CLK_PERIOD/2) macCoreClk = ~macCoreClk;
  end

  always @(negedge macCoreClk)
  begin
    if (txTimeDone_p)
      doneCount <= doneCount + 1;          // One-cycle pulse seen once
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkData(input string what, input logic [AXI_DATA_WIDTH-1:0] expected,
                           input logic [AXI_DATA_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h",
               testName, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic checkResp(input string what, input axiResp_t expected, input axiResp_t actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s %s expected %s actual %b", testName, what,
               expected.name(), actual);
      $display("TEST FAILED");
      $fatal(1, "Response mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite drivers entered and left on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic axiWrite(input logic [AXI_ADDR_WIDTH-1:0] addr,
                          input logic [AXI_DATA_WIDTH-1:0] data,
                          input logic [AXI_DATA_WIDTH/8-1:0] strb,
                          output axiResp_t resp, input int stall = 0);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!awready)
      @(negedge macCoreClk);
    checkData("wready with awready", 1, wready);
    @(negedge macCoreClk);                 // Address and data taken on the edge between
    awvalid = 1'b0;
    wvalid  = 1'b0;
    checkData("awready one cycle", 0, awready);
    while (!bvalid)
      @(negedge macCoreClk);
    repeat (stall) @(negedge macCoreClk);  // bready held low
    resp   = bresp;
    bready = 1'b1;
    @(negedge macCoreClk);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [AXI_ADDR_WIDTH-1:0] addr,
                         output logic [AXI_DATA_WIDTH-1:0] data,
                         output axiResp_t resp, input int stall = 0);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready)
      @(negedge macCoreClk);
    @(negedge macCoreClk);                 // Address taken on the edge between
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge macCoreClk);
    repeat (stall) @(negedge macCoreClk);  // rready held low
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge macCoreClk);
    rready = 1'b0;
  endtask

  function automatic int pickStall();
    return (stallMax == 0) ? 0 : $urandom_range(stallMax);
  endfunction

  task automatic writeReg(input logic [AXI_ADDR_WIDTH-1:0] addr,
                          input logic [AXI_DATA_WIDTH-1:0] data);
    axiResp_t resp;
    axiWrite(addr, data, 4'hF, resp, pickStall());
    checkResp($sformatf("write 0x%02h", addr), OKAY, resp);
  endtask

  task automatic readReg(input logic [AXI_ADDR_WIDTH-1:0] addr,
                         output logic [AXI_DATA_WIDTH-1:0] data);
    axiResp_t resp;
    axiRead(addr, data, resp, pickStall());
    checkResp($sformatf("read 0x%02h", addr), OKAY, resp);
  endtask

  task automatic checkReg(input string what, input logic [AXI_ADDR_WIDTH-1:0] addr,
                          input logic [AXI_DATA_WIDTH-1:0] expected);
    logic [AXI_DATA_WIDTH-1:0] val;
    readReg(addr, val);
    checkData(what, expected, val);
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model and run helpers
  ////////////////////////////////////////////////////////////
  function automatic void refModel(input logic [LENGTH_WIDTH-1:0] len, input nBitPSymb_t ndbps,
                                   input logic roundUp, input logic [SYMBDUR_WIDTH-1:0] symbDur,
                                   input logic [PREAMBLE_WIDTH-1:0] preamble,
                                   output nBit_t nSymb, output nBitPSymb_t rem,
                                   output duration_t dur);
    int unsigned coded;
    coded = SERVICE_BITS + 8 * int'(len) + TAIL_BITS;  // Service, payload, tail
    nSymb = '0;
    rem   = '0;
    if (ndbps != '0)
    begin
      nSymb = nBit_t'(coded / ndbps);
      rem   = nBitPSymb_t'(coded % ndbps);
      if (roundUp && rem != '0)
        nSymb = nBit_t'(nSymb + 1);
    end
    dur = duration_t'(preamble) + duration_t'(nSymb) * duration_t'(symbDur);
  endfunction

  task automatic startRun(input logic roundUp);
    writeReg(REG_CTRL, {30'b0, roundUp, 1'b1});
    repeat (2) @(negedge macCoreClk);      // Sticky done cleared by then
  endtask

  task automatic waitDone();
    logic [AXI_DATA_WIDTH-1:0] status;
    status = '0;
    while (!status[1])
      readReg(REG_STATUS, status);
  endtask

  task automatic runCalc(input logic [LENGTH_WIDTH-1:0] len, input nBitPSymb_t ndbps,
                         input logic roundUp, input logic [SYMBDUR_WIDTH-1:0] symbDur,
                         input logic [PREAMBLE_WIDTH-1:0] preamble);
    writeReg(REG_LENGTH, AXI_DATA_WIDTH'(len));
    writeReg(REG_NDBPS, AXI_DATA_WIDTH'(ndbps));
    writeReg(REG_TIMING, {8'h00, preamble, symbDur});
    expectedDones++;
    startRun(roundUp);
    waitDone();
  endtask

  task automatic checkResult(input nBit_t expNSymb, input nBitPSymb_t expRem,
                             input duration_t expDur, input logic expDivByZero);
    checkReg("nSymb", REG_NSYMB, AXI_DATA_WIDTH'(expNSymb));
    checkReg("remainder", REG_REMAINDER, AXI_DATA_WIDTH'(expRem));
    checkReg("duration", REG_DURATION, expDur);
    checkReg("status", REG_STATUS, {29'b0, expDivByZero, 2'b10}); // Done, idle
    checkData("done pulses", expectedDones, doneCount);
  endtask

  task automatic runAndCheck(input logic [LENGTH_WIDTH-1:0] len, input nBitPSymb_t ndbps,
                             input logic roundUp, input logic [SYMBDUR_WIDTH-1:0] symbDur,
                             input logic [PREAMBLE_WIDTH-1:0] preamble);
    nBit_t      expNSymb;
    nBitPSymb_t expRem;
    duration_t  expDur;
    refModel(len, ndbps, roundUp, symbDur, preamble, expNSymb, expRem, expDur);
    runCalc(len, ndbps, roundUp, symbDur, preamble);
    checkResult(expNSymb, expRem, expDur, ndbps == '0);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic resetState();
    testName = "resetState";
    for (int offs = 0; offs <= int'(REG_REMAINDER); offs += 4)
      checkReg($sformatf("offset 0x%02h", offs), AXI_ADDR_WIDTH'(offs), '0);
  endtask

  task automatic fixedCases();
    testName = "fixedCases";
    runCalc(100, 26, 1'b0, 40, 200);       // 822 coded bits
    checkResult(31, 16, 1440, 1'b0);
    runCalc(100, 26, 1'b1, 40, 200);
    checkResult(32, 16, 1480, 1'b0);
    runCalc(1, 30, 1'b1, 40, 200);         // Exact, no round-up
    checkResult(1, 0, 240, 1'b0);
  endtask

  task automatic randomCases();
    testName = "randomCases";
    for (int i = 0; i < RANDOM_CASES; i++)
      runAndCheck($urandom_range(65535), $urandom_range(4095, 1), $urandom_range(1),
                  $urandom_range(255), $urandom_range(65535));
  endtask

  task automatic zeroDivisor();
    testName = "zeroDivisor";
    runCalc(50, 0, 1'b1, 40, 300);
    checkResult(0, 0, 300, 1'b1);          // Preamble only
    runAndCheck(50, 24, 1'b1, 40, 300);    // Valid start clears the flag
  endtask

  task automatic busErrors();
    axiResp_t                  resp;
    logic [AXI_DATA_WIDTH-1:0] val;
    logic [AXI_DATA_WIDTH-1:0] nSymbBefore;
    testName = "busErrors";
    axiRead(8'h20, val, resp);
    checkResp("read 0x20", SLVERR, resp);
    axiWrite(8'h20, 32'h1234, 4'hF, resp);
    checkResp("write 0x20", SLVERR, resp);
    // Read-only write ignored
    readReg(REG_NSYMB, nSymbBefore);
    axiWrite(REG_NSYMB, 32'hFFFF, 4'hF, resp);
    checkResp("write nSymb", OKAY, resp);
    checkReg("nSymb kept", REG_NSYMB, nSymbBefore);
    // Second start during a run
    writeReg(REG_LENGTH, 100);
    writeReg(REG_NDBPS, 26);
    writeReg(REG_TIMING, {8'h00, 16'd200, 8'd40});
    expectedDones++;
    startRun(1'b0);
    writeReg(REG_LENGTH, 1000);
    writeReg(REG_CTRL, 32'h1);
    waitDone();
    checkResult(31, 16, 1440, 1'b0);
    repeat (NBIT_WIDTH + 4) @(negedge macCoreClk);  // No late second run
    checkData("done pulses after", expectedDones, doneCount);
    // Byte strobes on the timing register
    writeReg(REG_TIMING, 32'h0012_3456);
    axiWrite(REG_TIMING, 32'hAABB_CCDD, 4'b0010, resp);
    checkResp("strobe write", OKAY, resp);
    checkReg("timing lane 1", REG_TIMING, 32'h0012_CC56);
    axiWrite(REG_TIMING, 32'hAABB_CCDD, 4'b0101, resp);
    checkResp("strobe write lanes 0 and 2", OKAY, resp);
    checkReg("timing lanes 0 and 2", REG_TIMING, 32'h00BB_CCDD);
  endtask

  task automatic backPressure();
    testName = "backPressure";
    stallMax = 10;
    for (int i = 0; i < STALL_CASES; i++)
      runAndCheck($urandom_range(65535), $urandom_range(4095, 1), $urandom_range(1),
                  $urandom_range(255), $urandom_range(65535));
    stallMax = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial
  begin
    macCoreClkHardRst_n = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    void'($urandom(38));
    repeat (10) @(negedge macCoreClk);
    macCoreClkHardRst_n = 1'b1;
    @(negedge macCoreClk);
    resetState();
    fixedCases();
    randomCases();
    zeroDivisor();
    busErrors();
    backPressure();
    if (txTimeTop_inst.txTimeTop_assertions_inst.failCount == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      $display("Bound assertions failed %0d times",
               txTimeTop_inst.txTimeTop_assertions_inst.failCount);
      $display("TEST FAILED");
      $fatal(1, "Assertion failures");
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge macCoreClk);
    $display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: verification/txTimeTop_assertions.sv
// TX time bound checks
`timescale 1ns/1ps

module txTimeTop_assertions import txTimePkg::*;
(
  input logic                      macCoreClk,
  input logic                      macCoreClkHardRst_n,
  input logic                      bvalid,
  input logic                      bready,
  input axiResp_t                  bresp,
  input logic                      rvalid,
  input logic                      rready,
  input logic [AXI_DATA_WIDTH-1:0] rdata,
  input logic                      divDone_p,
  input logic                      busy,
  input logic                      txTimeDone_p
);

  int failCount = 0;    // Failed assertion count

  // Write response held until taken
  bHold: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else
  begin
    failCount++;
    $error("Write response dropped or changed before bready");
  end

  // Read data held until taken
  rHold: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
  else
  begin
    failCount++;
    $error("Read response dropped or changed before rready");
  end

  divPulse: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    divDone_p |=> !divDone_p)
  else
  begin
    failCount++;
    $error("Divider done longer than one cycle");
  end

  // Interrupt only at the end of a run
  doneAfterBusy: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    txTimeDone_p |-> $past(busy))
  else
  begin
    failCount++;
    $error("Done pulse without busy the cycle before");
  end

endmodule

// File: verilog/symbolDivider.sv
`timescale 1ns/1ps
// Restoring symbol divider

module symbolDivider import txTimePkg::*;
(
  input  logic macCoreClk,
  input  logic macCoreClkHardRst_n,
  divIf.div    div
);

  logic                                  running;
  logic [STEPCNT_WIDTH-1:0]              stepCnt;     // Quotient bits left minus one
  logic                                  lastStep;
  logic                                  doneReg;
  logic                                  roundUpReg;
  nBit_t                                 remReg;      // Partial remainder
  nBit_t                                 quotReg;
  logic [NBIT_WIDTH+NBITPSYMB_WIDTH-2:0] alignedDiv;  // Divisor shifted under current bit
  logic                                  canSub;
  nBit_t                                 remStep;
  nBit_t                                 quotStep;
  logic                                  roundInc;

  ////////////////////////////////////////////////////////////
  // One quotient bit per cycle
  ////////////////////////////////////////////////////////////
  assign canSub   = {{(NBITPSYMB_WIDTH-1){1'b0}}, remReg} >= alignedDiv;
  // canSub keeps alignedDiv below 2**NBIT_WIDTH so the low slice is exact
  assign remStep  = canSub ? remReg - alignedDiv[NBIT_WIDTH-1:0] : remReg;
  assign quotStep = {quotReg[NBIT_WIDTH-2:0], canSub};
  assign lastStep = running && (stepCnt == '0);
  assign roundInc = roundUpReg && (remStep != '0);  // Only on inexact result

  // Step control
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      running <= 1'b0;
      stepCnt <= '0;
      doneReg <= 1'b0;
    end
    else
    begin
      doneReg <= lastStep;                   // Pulse after final bit
      if (div.divStart_p)
      begin
        running <= 1'b1;
        stepCnt <= STEPCNT_WIDTH'(NBIT_WIDTH - 1);
      end
      else if (lastStep)
        running <= 1'b0;
      else if (running)
        stepCnt <= stepCnt - 1'b1;
    end
  end

  // Datapath
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      remReg     <= '0;
      quotReg    <= '0;
      alignedDiv <= '0;
      roundUpReg <= 1'b0;
    end
    else if (div.divStart_p)
    begin
      // Load cycle
      remReg     <= div.dividend;
      quotReg    <= '0;
      alignedDiv <= {div.divisor, {(NBIT_WIDTH-1){1'b0}}}; // MSB of quotient first
      roundUpReg <= div.roundUp;
    end
    else if (running)
    begin
      remReg     <= remStep;
      alignedDiv <= alignedDiv >> 1;
      if (lastStep)
        quotReg <= quotStep + nBit_t'(roundInc);     // Round-up folded into last bit
      else
        quotReg <= quotStep;
    end
  end

  assign div.quotient  = quotReg;
  assign div.remainder = remReg[NBITPSYMB_WIDTH-1:0]; // Always below divisor
  assign div.divDone_p = doneReg;

endmodule

// File: verilog/txTimeCtrl.sv
`timescale 1ns/1ps
// TX time control sequencer

module txTimeCtrl import txTimePkg::*;
(
  input  logic macCoreClk,
  input  logic macCoreClkHardRst_n,
  txCfgIf.ctrl cfg,
  divIf.ctrl   div
);

  typedef enum logic [1:0]
  {
    IDLE,
    DIVIDING,
    FINISHING       // Zero divisor path only
  } ctrlState_t;

  ctrlState_t                state;
  logic                      startOk;      // Start accepted in idle
  logic                      zeroDiv;
  logic                      divStartReg;
  logic                      doneReg;
  logic                      finish;
  nBit_t                     dividendReg;
  nBitPSymb_t                divisorReg;
  logic                      roundUpReg;
  logic [SYMBDUR_WIDTH-1:0]  symbDurReg;
  logic [PREAMBLE_WIDTH-1:0] preambleReg;
  nBit_t                     nSymbNext;
  nBitPSymb_t                remNext;
  nBit_t                     nSymbReg;
  nBitPSymb_t                remReg;
  duration_t                 durReg;
  logic                      divByZeroReg;

  assign startOk   = (state == IDLE) && cfg.start_p; // Start while busy dropped
  assign finish    = ((state == DIVIDING) && div.divDone_p) || (state == FINISHING);
  assign nSymbNext = zeroDiv ? '0 : div.quotient;
  assign remNext   = zeroDiv ? '0 : div.remainder;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      state       <= IDLE;
      zeroDiv     <= 1'b0;
      divStartReg <= 1'b0;
      doneReg     <= 1'b0;
    end
    else
    begin
      divStartReg <= 1'b0;
      doneReg     <= finish;                 // Done with the results
      case (state)
        IDLE:
          if (startOk)
          begin
            zeroDiv     <= (cfg.nBitPSymb == '0);
            divStartReg <= (cfg.nBitPSymb != '0);    // Divider skipped on zero
            state       <= (cfg.nBitPSymb == '0) ? FINISHING : DIVIDING;
          end
        DIVIDING:
          if (div.divDone_p)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Operands held for the whole run
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      dividendReg <= '0;
      divisorReg  <= '0;
      roundUpReg  <= 1'b0;
      symbDurReg  <= '0;
      preambleReg <= '0;
    end
    else if (startOk)
    begin
      dividendReg <= nBit_t'({cfg.psduLength, 3'b000}) + nBit_t'(SERVICE_BITS + TAIL_BITS);
      divisorReg  <= cfg.nBitPSymb;
      roundUpReg  <= cfg.roundUp;
      symbDurReg  <= cfg.symbDur;
      preambleReg <= cfg.preambleDur;
    end
  end

  ////////////////////////////////////////////////////////////
  // Results
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      nSymbReg     <= '0;
      remReg       <= '0;
      durReg       <= '0;
      divByZeroReg <= 1'b0;
    end
    else if (startOk)
      divByZeroReg <= 1'b0;                  // Cleared by next valid start
    else if (finish)
    begin
      nSymbReg     <= nSymbNext;
      remReg       <= remNext;
      durReg       <= duration_t'(preambleReg) +
                      duration_t'(nSymbNext) * duration_t'(symbDurReg); // Preamble + symbols
      divByZeroReg <= zeroDiv;
    end
  end

  assign div.divStart_p = divStartReg;
  assign div.dividend   = dividendReg;
  assign div.divisor    = divisorReg;
  assign div.roundUp    = roundUpReg;

  assign cfg.busy      = (state != IDLE);
  assign cfg.done_p    = doneReg;
  assign cfg.divByZero = divByZeroReg;
  assign cfg.nSymb     = nSymbReg;
  assign cfg.remainder = remReg;
  assign cfg.duration  = durReg;

endmodule

// File: verilog/txTimeIfs.sv
`timescale 1ns/1ps
// Configuration and divider interfaces

// Register block to control block
interface txCfgIf import txTimePkg::*; ();
  logic                       start_p;      // One-cycle start
  logic [LENGTH_WIDTH-1:0]    psduLength;
  nBitPSymb_t                 nBitPSymb;
  logic                       roundUp;
  logic [SYMBDUR_WIDTH-1:0]   symbDur;
  logic [PREAMBLE_WIDTH-1:0]  preambleDur;
  logic                       busy;
  logic                       done_p;       // Results valid from here
  logic                       divByZero;
  nBit_t                      nSymb;
  nBitPSymb_t                 remainder;
  duration_t                  duration;

  modport regs
  (
    output start_p, psduLength, nBitPSymb, roundUp, symbDur, preambleDur,
    input  busy, done_p, divByZero, nSymb, remainder, duration
  );

  modport ctrl
  (
    input  start_p, psduLength, nBitPSymb, roundUp, symbDur, preambleDur,
    output busy, done_p, divByZero, nSymb, remainder, duration
  );
endinterface

// Control block to divider
interface divIf import txTimePkg::*; ();
  logic       divStart_p;   // Only issued while divider idle
  nBit_t      dividend;
  nBitPSymb_t divisor;
  logic       roundUp;
  nBit_t      quotient;
  nBitPSymb_t remainder;    // Before round-up
  logic       divDone_p;

  modport ctrl (output divStart_p, dividend, divisor, roundUp,
                input  quotient, remainder, divDone_p);

  modport div  (input  divStart_p, dividend, divisor, roundUp,
                output quotient, remainder, divDone_p);
endinterface

// File: verilog/txTimePkg.sv
// TX time calculator definitions
package txTimePkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////
  localparam int NBIT_WIDTH      = 20;                    // Coded bits and quotient
  localparam int NBITPSYMB_WIDTH = 12;                    // Divisor and remainder
  localparam int LENGTH_WIDTH    = 16;                    // Packet length in bytes
  localparam int SYMBDUR_WIDTH   = 8;                     // Symbol time in 100 ns units
  localparam int PREAMBLE_WIDTH  = 16;                    // Preamble time in 100 ns units
  localparam int DURATION_WIDTH  = 32;
  localparam int STEPCNT_WIDTH   = $clog2(NBIT_WIDTH);    // Divider step counter
  localparam int AXI_ADDR_WIDTH  = 8;
  localparam int AXI_DATA_WIDTH  = 32;

  // Bits added around the payload
  localparam int SERVICE_BITS = 16;
  localparam int TAIL_BITS    = 6;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_CTRL      = 8'h00; // Start and roundUp
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_LENGTH    = 8'h04;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_NDBPS     = 8'h08;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_TIMING    = 8'h0C; // symbDur low, preamble above
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS    = 8'h10; // First read-only offset
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_NSYMB     = 8'h14;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_DURATION  = 8'h18;
  localparam logic [AXI_ADDR_WIDTH-1:0] REG_REMAINDER = 8'h1C; // Last mapped offset

  // Shared payload types
  typedef logic [NBIT_WIDTH-1:0]      nBit_t;
  typedef logic [NBITPSYMB_WIDTH-1:0] nBitPSymb_t;
  typedef logic [DURATION_WIDTH-1:0]  duration_t;

  // AXI response codes in use
  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axiResp_t;

endpackage

// File: verilog/txTimeRegs.sv
`timescale 1ns/1ps
// AXI4-Lite register block

module txTimeRegs import txTimePkg::*;
(
  input  logic                        macCoreClk,
  input  logic                        macCoreClkHardRst_n,
  // Write channels
  input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output axiResp_t                    bresp,
  output logic                        bvalid,
  input  logic                        bready,
  // Read channels
  input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [AXI_DATA_WIDTH-1:0]   rdata,
  output axiResp_t                    rresp,
  output logic                        rvalid,
  input  logic                        rready,
  txCfgIf.regs                        cfg
);

  logic                                    wrReady;      // Shared aw/w ready
  logic                                    wrAccept;
  logic                                    rdAccept;
  logic                                    startReg;
  logic                                    doneSticky;
  logic                                    roundUpReg;
  logic [LENGTH_WIDTH-1:0]                 lengthReg;
  nBitPSymb_t                              nBitPSymbReg;
  logic [PREAMBLE_WIDTH+SYMBDUR_WIDTH-1:0] timingReg;    // {preamble, symbDur}
  logic [AXI_DATA_WIDTH-1:0]               rdValue;
  logic [AXI_DATA_WIDTH-1:0]               wrMerged;

  // Offset inside the map and word aligned
  function automatic logic isMapped(input logic [AXI_ADDR_WIDTH-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= REG_REMAINDER);
  endfunction

  // Readback view of one register
  function automatic logic [AXI_DATA_WIDTH-1:0] regValue(input logic [AXI_ADDR_WIDTH-1:0] addr);
    logic [AXI_DATA_WIDTH-1:0] val;
    case (addr)
      REG_CTRL:      val = AXI_DATA_WIDTH'({roundUpReg, 1'b0}); // Start reads 0
      REG_LENGTH:    val = AXI_DATA_WIDTH'(lengthReg);
      REG_NDBPS:     val = AXI_DATA_WIDTH'(nBitPSymbReg);
      REG_TIMING:    val = AXI_DATA_WIDTH'(timingReg);
      REG_STATUS:    val = AXI_DATA_WIDTH'({cfg.divByZero, doneSticky, cfg.busy});
      REG_NSYMB:     val = AXI_DATA_WIDTH'(cfg.nSymb);
      REG_DURATION:  val = cfg.duration;
      REG_REMAINDER: val = AXI_DATA_WIDTH'(cfg.remainder);
      default:       val = '0;
    endcase
    return val;
  endfunction

  // Byte lanes with strobe take new data
  function automatic logic [AXI_DATA_WIDTH-1:0] mergeBytes(
    input logic [AXI_DATA_WIDTH-1:0]   oldVal,
    input logic [AXI_DATA_WIDTH-1:0]   newVal,
    input logic [AXI_DATA_WIDTH/8-1:0] strb);
    logic [AXI_DATA_WIDTH-1:0] res;
    res = oldVal;
    for (int i = 0; i < AXI_DATA_WIDTH/8; i++)
    begin
      if (strb[i])
        res[8*i +: 8] = newVal[8*i +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////
  assign awready  = wrReady;
  assign wready   = wrReady;
  assign wrAccept = wrReady && awvalid && wvalid;
  assign arready  = !rvalid;                 // Free when no read pending
  assign rdAccept = arvalid && arready;

  always_comb
  begin
    rdValue  = regValue(araddr);
    wrMerged = mergeBytes(regValue(awaddr), wdata, wstrb); // Read-modify-write view
  end

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      wrReady <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= OKAY;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rresp   <= OKAY;
    end
    else
    begin
      // One-cycle ready once both channels present
      wrReady <= !wrReady && !bvalid && awvalid && wvalid;
      if (wrAccept)
      begin
        bvalid <= 1'b1;
        bresp  <= isMapped(awaddr) ? OKAY : SLVERR;
      end
      else if (bready)
        bvalid <= 1'b0;

      if (rdAccept)
      begin
        rvalid <= 1'b1;
        rdata  <= rdValue;
        rresp  <= isMapped(araddr) ? OKAY : SLVERR;
      end
      else if (rready)
        rvalid <= 1'b0;                      // Held until taken
    end
  end

  ////////////////////////////////////////////////////////////
  // Configuration fields
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      startReg     <= 1'b0;
      doneSticky   <= 1'b0;
      roundUpReg   <= 1'b0;
      lengthReg    <= '0;
      nBitPSymbReg <= '0;
      timingReg    <= '0;
    end
    else
    begin
      startReg <= wrAccept && (awaddr == REG_CTRL) && wstrb[0] && wdata[0]; // Self-clearing
      if (cfg.done_p)
        doneSticky <= 1'b1;
      else if (startReg)
        doneSticky <= 1'b0;                  // New run clears done
      if (wrAccept)
      begin
        // Read-only and unmapped offsets fall through
        case (awaddr)
          REG_CTRL:   roundUpReg   <= wrMerged[1];
          REG_LENGTH: lengthReg    <= wrMerged[LENGTH_WIDTH-1:0];
          REG_NDBPS:  nBitPSymbReg <= wrMerged[NBITPSYMB_WIDTH-1:0];
          REG_TIMING: timingReg    <= wrMerged[PREAMBLE_WIDTH+SYMBDUR_WIDTH-1:0];
          default:    ;
        endcase
      end
    end
  end

  assign cfg.start_p     = startReg;
  assign cfg.psduLength  = lengthReg;
  assign cfg.nBitPSymb   = nBitPSymbReg;
  assign cfg.roundUp     = roundUpReg;
  assign cfg.symbDur     = timingReg[SYMBDUR_WIDTH-1:0];
  assign cfg.preambleDur = timingReg[PREAMBLE_WIDTH+SYMBDUR_WIDTH-1:SYMBDUR_WIDTH];

endmodule

// File: verilog/txTimeTop.sv
`timescale 1ns/1ps
// TX time calculator top level

module txTimeTop import txTimePkg::*;
(
  input  logic                        macCoreClk,
  input  logic                        macCoreClkHardRst_n,
  // AXI4-Lite write
  input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output axiResp_t                    bresp,
  output logic                        bvalid,
  input  logic                        bready,
  // AXI4-Lite read
  input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [AXI_DATA_WIDTH-1:0]   rdata,
  output axiResp_t                    rresp,
  output logic                        rvalid,
  input  logic                        rready,
  output logic                        txTimeDone_p   // Interrupt pulse
);

  txCfgIf cfgBus ();
  divIf   divBus ();

  txTimeRegs txTimeRegs_inst
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata  (wdata),  .wstrb   (wstrb),   .wvalid  (wvalid), .wready (wready),
    .bresp  (bresp),  .bvalid  (bvalid),  .bready  (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata  (rdata),  .rresp   (rresp),   .rvalid  (rvalid), .rready (rready),
    .cfg    (cfgBus)
  );

  txTimeCtrl txTimeCtrl_inst
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .cfg                 (cfgBus),
    .div                 (divBus)
  );

  symbolDivider symbolDivider_inst
  (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .div                 (divBus)
  );

  assign txTimeDone_p = cfgBus.done_p;

endmodule
